// File: design/snake_params.svh
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// tile edge in pixels, the grid is counted in these
`define SNAKE_TILE 10

`define SNAKE_MAX_LEN 8
`define SNAKE_START_LEN 4
`define SNAKE_STEP_FRAMES 6 // frames per game step
`define SNAKE_KEY_DEPTH 4

// default 640x480 raster
`define SNAKE_H_ACTIVE 640
`define SNAKE_H_TOTAL 800
`define SNAKE_H_SYNC_START 656
`define SNAKE_H_SYNC_END 752

`define SNAKE_V_ACTIVE 480
`define SNAKE_V_TOTAL 525
`define SNAKE_V_SYNC_START 490
`define SNAKE_V_SYNC_END 492

// pixel counters and tile coordinates
`define SNAKE_COORD_W 11
`define SNAKE_TILE_W 7

`endif

// File: design/snakeGeomPkg.sv
`include "snake_params.svh"

package snakeGeomPkg;

    typedef struct packed {
        logic [`SNAKE_TILE_W-1:0] x;
        logic [`SNAKE_TILE_W-1:0] y;
    } tileT;

    // one pixel of the raster, sync is active low
    typedef struct packed {
        logic [`SNAKE_COORD_W-1:0] x;
        logic [`SNAKE_COORD_W-1:0] y;
        logic                      active;
        logic                      hsync;
        logic                      vsync;
    } rasterT;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // body[0] is always the head, slots at len and above are not live
    typedef struct packed {
        tileT                      head;
        tileT                      apple;
        logic [3:0]                len;
        logic                      dead;
        tileT [`SNAKE_MAX_LEN-1:0] body;
    } gameStatusT;

endpackage

// File: design/snakeCtrlPkg.sv
package snakeCtrlPkg;

    typedef enum logic [1:0] {
        dirUp    = 2'd0,
        dirDown  = 2'd1,
        dirLeft  = 2'd2,
        dirRight = 2'd3
    } dirT;

    typedef struct packed {
        logic       valid;
        logic [7:0] code; // PS/2 make code
    } keyCmdT;

    // arrow key make codes
    localparam logic [7:0] keyUp    = 8'h75;
    localparam logic [7:0] keyDown  = 8'h72;
    localparam logic [7:0] keyLeft  = 8'h6B;
    localparam logic [7:0] keyRight = 8'h74;

endpackage

// File: design/rasterScan.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module rasterScan
    import snakeGeomPkg::*;
#(
    parameter int hActive    = `SNAKE_H_ACTIVE,
    parameter int hTotal     = `SNAKE_H_TOTAL,
    parameter int hSyncStart = `SNAKE_H_SYNC_START,
    parameter int hSyncEnd   = `SNAKE_H_SYNC_END,
    parameter int vActive    = `SNAKE_V_ACTIVE,
    parameter int vTotal     = `SNAKE_V_TOTAL,
    parameter int vSyncStart = `SNAKE_V_SYNC_START,
    parameter int vSyncEnd   = `SNAKE_V_SYNC_END
) (
    input  logic   clk25,
    input  logic   reset,
    output rasterT raster,
    output logic   frameEnd
);
    localparam int coordW = `SNAKE_COORD_W;
    localparam logic [coordW-1:0] hLast = coordW'(hTotal - 1);
    localparam logic [coordW-1:0] vLast = coordW'(vTotal - 1);

    logic [coordW-1:0] hCount, vCount;
    logic lineEnd;

    assign lineEnd  = (hCount == hLast);
    assign frameEnd = lineEnd && (vCount == vLast); // last pixel of last line

    always_ff @(posedge clk25) begin
        if (reset) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            vCount <= (vCount == vLast) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    always_comb begin
        raster.x      = hCount;
        raster.y      = vCount;
        raster.active = (hCount < hActive) && (vCount < vActive);
        // syncs pulse low inside their windows
        raster.hsync  = !((hCount >= hSyncStart) && (hCount < hSyncEnd));
        raster.vsync  = !((vCount >= vSyncStart) && (vCount < vSyncEnd));
    end

endmodule

// File: design/keyCommandQueue.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module keyCommandQueue #(
    parameter type payloadT = logic [7:0],
    parameter int  depth    = `SNAKE_KEY_DEPTH
) (
    input  logic    clk25,
    input  logic    reset,
    input  payloadT pushData,
    input  logic    pushValid,
    input  logic    pop,
    output payloadT headData,
    output logic    nonEmpty,
    output logic    credit
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

    payloadT mem [depth];
    logic [ptrW-1:0] rdPtr, wrPtr;
    logic [ptrW:0] count;
    logic doPop;

    function automatic logic [ptrW-1:0] advance(input logic [ptrW-1:0] ptr);
        return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign nonEmpty = (count != '0);
    assign headData = mem[rdPtr];
    assign doPop    = pop && nonEmpty; // pop of an empty queue is dropped

    // sender owns the credits, so every push is taken
    always_ff @(posedge clk25) begin
        if (pushValid) mem[wrPtr] <= pushData;
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            rdPtr  <= '0;
            wrPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= doPop; // one credit back per entry gone
            if (pushValid) wrPtr <= advance(wrPtr);
            if (doPop) rdPtr <= advance(rdPtr);
            case ({pushValid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: design/snakeEngine.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module snakeEngine
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
#(
    parameter int gridW = 64,
    parameter int gridH = 48
) (
    input  logic       clk25,
    input  logic       reset,
    input  logic       frameEnd,
    input  keyCmdT     keyHead,
    input  logic       keyReady,
    output logic       keyPop,
    output gameStatusT status
);
    localparam int tileW = `SNAKE_TILE_W;
    localparam int maxLen = `SNAKE_MAX_LEN;

    tileT [maxLen-1:0] body;
    tileT apple, newHead;
    logic [3:0] len, liveCount;
    logic dead, step, grow, hit;
    dirT dir, nextDir;
    logic [$clog2(`SNAKE_STEP_FRAMES)-1:0] stepCount;
    logic [15:0] frameCount, frameNext;

    assign step      = frameEnd && (stepCount == `SNAKE_STEP_FRAMES - 1);
    assign keyPop    = step && keyReady; // codes drain even after death
    assign frameNext = frameCount + 1'b1;

    // only a quarter turn is accepted
    always_comb begin
        nextDir = dir;
        if (keyPop && keyHead.valid) begin
            case (keyHead.code)
                keyUp:    if (dir == dirLeft || dir == dirRight) nextDir = dirUp;
                keyDown:  if (dir == dirLeft || dir == dirRight) nextDir = dirDown;
                keyLeft:  if (dir == dirUp || dir == dirDown) nextDir = dirLeft;
                keyRight: if (dir == dirUp || dir == dirDown) nextDir = dirRight;
                default:  nextDir = dir;
            endcase
        end
    end

    always_comb begin
        newHead = body[0];
        hit = 1'b0;
        case (nextDir)
            dirUp: begin
                hit = (body[0].y == '0);
                newHead.y = body[0].y - 1'b1;
            end
            dirDown: begin
                hit = (body[0].y == tileW'(gridH - 1));
                newHead.y = body[0].y + 1'b1;
            end
            dirLeft: begin
                hit = (body[0].x == '0);
                newHead.x = body[0].x - 1'b1;
            end
            default: begin
                hit = (body[0].x == tileW'(gridW - 1));
                newHead.x = body[0].x + 1'b1;
            end
        endcase
        grow = (newHead == apple);
        // tail slot frees up unless this step grows
        liveCount = grow ? len : len - 1'b1;
        for (int i = 0; i < maxLen; i++) begin
            if (i < liveCount && body[i] == newHead) hit = 1'b1;
        end
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int i = 0; i < maxLen; i++) begin
                body[i].x <= (i < `SNAKE_START_LEN) ? tileW'(`SNAKE_START_LEN - 1 - i) : '0;
                body[i].y <= '0;
            end
            apple      <= '{x: tileW'(6), y: tileW'(2)};
            len        <= 4'(`SNAKE_START_LEN);
            dir        <= dirRight;
            dead       <= 1'b0;
            stepCount  <= '0;
            frameCount <= '0;
        end else begin
            if (frameEnd) begin
                frameCount <= frameNext;
                stepCount  <= step ? '0 : stepCount + 1'b1;
            end
            if (step && !dead) begin
                if (hit) begin
                    dead <= 1'b1; // freeze in place
                end else begin
                    dir  <= nextDir;
                    body <= {body[maxLen-2:0], newHead}; // old tail lands in slot len
                    if (grow) begin
                        if (len < maxLen) len <= len + 1'b1;
                        apple <= '{x: tileW'(frameNext % gridW), y: tileW'(frameNext % gridH)};
                    end
                end
            end
        end
    end

    assign status = '{head: body[0], apple: apple, len: len, dead: dead, body: body};

endmodule

// File: design/pixelComposer.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module pixelComposer
    import snakeGeomPkg::*;
(
    input  logic       clk25,
    input  logic       reset,
    input  rasterT     raster,
    input  gameStatusT status,
    output rgbT        rgb,
    output logic       hsync,
    output logic       vsync
);
    localparam int subW = $clog2(`SNAKE_TILE);

    logic [subW-1:0] subX, subY, curSubX, curSubY;
    logic [`SNAKE_TILE_W-1:0] tileX, tileY;
    tileT pixTile;
    logic onSnake;
    rgbT colour;

    // registers hold the previous pixel, this works out the current one
    always_comb begin
        curSubX = subX + 1'b1;
        pixTile.x = tileX;
        if (raster.x == '0) begin
            curSubX = '0;
            pixTile.x = '0;
        end else if (subX == subW'(`SNAKE_TILE - 1)) begin
            curSubX = '0;
            pixTile.x = tileX + 1'b1;
        end
        curSubY = subY;
        pixTile.y = tileY;
        if (raster.x == '0 && raster.y == '0) begin
            curSubY = '0;
            pixTile.y = '0;
        end else if (raster.x == '0) begin
            curSubY = (subY == subW'(`SNAKE_TILE - 1)) ? '0 : subY + 1'b1;
            pixTile.y = (subY == subW'(`SNAKE_TILE - 1)) ? tileY + 1'b1 : tileY;
        end
    end

    always_comb begin
        onSnake = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            if (i < status.len && status.body[i] == pixTile) onSnake = 1'b1;
        end
        if (!raster.active || onSnake) colour = '{red: 4'h0, green: 4'h0, blue: 4'h0};
        else if (pixTile == status.apple) colour = '{red: 4'h0, green: 4'hF, blue: 4'h0};
        else colour = '{red: 4'hF, green: 4'hF, blue: 4'hF};
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            subX  <= '0;
            subY  <= '0;
            tileX <= '0;
            tileY <= '0;
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            subX  <= curSubX;
            subY  <= curSubY;
            tileX <= pixTile.x;
            tileY <= pixTile.y;
            rgb   <= colour;
            hsync <= raster.hsync; // kept in step with rgb
            vsync <= raster.vsync;
        end
    end

endmodule

// File: design/snakeTop.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module snakeTop
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
#(
    parameter int hActive    = `SNAKE_H_ACTIVE,
    parameter int hTotal     = `SNAKE_H_TOTAL,
    parameter int hSyncStart = `SNAKE_H_SYNC_START,
    parameter int hSyncEnd   = `SNAKE_H_SYNC_END,
    parameter int vActive    = `SNAKE_V_ACTIVE,
    parameter int vTotal     = `SNAKE_V_TOTAL,
    parameter int vSyncStart = `SNAKE_V_SYNC_START,
    parameter int vSyncEnd   = `SNAKE_V_SYNC_END
) (
    input  logic       clk25,
    input  logic       reset,
    input  keyCmdT     keyCmd,
    output logic       keyCredit,
    output rgbT        rgb,
    output logic       hsync,
    output logic       vsync,
    output gameStatusT status
);
    localparam int gridW = hActive / `SNAKE_TILE;
    localparam int gridH = vActive / `SNAKE_TILE;

    rasterT raster;
    keyCmdT keyHead;
    logic frameEnd, keyReady, keyPop;

    rasterScan #(
        .hActive(hActive), .hTotal(hTotal), .hSyncStart(hSyncStart), .hSyncEnd(hSyncEnd),
        .vActive(vActive), .vTotal(vTotal), .vSyncStart(vSyncStart), .vSyncEnd(vSyncEnd)
    ) scanner (.clk25, .reset, .raster, .frameEnd);

    keyCommandQueue #(.payloadT(keyCmdT), .depth(`SNAKE_KEY_DEPTH)) keyQueue (
        .clk25, .reset, .pushData(keyCmd), .pushValid(keyCmd.valid), .pop(keyPop),
        .headData(keyHead), .nonEmpty(keyReady), .credit(keyCredit)
    );

    snakeEngine #(.gridW(gridW), .gridH(gridH)) engine (
        .clk25, .reset, .frameEnd, .keyHead, .keyReady, .keyPop, .status
    );

    pixelComposer composer (.clk25, .reset, .raster, .status, .rgb, .hsync, .vsync);

endmodule

// File: tb/snake_sva.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module snake_sva
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
#(
    parameter int hTotal = `SNAKE_H_TOTAL,
    parameter int vTotal = `SNAKE_V_TOTAL
) (
    input logic       clk25,
    input logic       reset,
    input keyCmdT     keyCmd,
    input logic       keyCredit,
    input logic       frameEnd,
    input logic       hsync,
    input logic       vsync,
    input gameStatusT status
);
    int inFlight; // commands pushed and not yet credited back
    int frameGap;
    int failCount = 0;

    always_ff @(posedge clk25) begin
        if (reset) begin
            inFlight <= 0;
            frameGap <= 0;
        end else begin
            inFlight <= inFlight + int'(keyCmd.valid) - int'(keyCredit);
            frameGap <= frameEnd ? 0 : frameGap + 1;
        end
    end

    creditSpent: assert property (@(posedge clk25) disable iff (reset)
        keyCmd.valid |-> inFlight < `SNAKE_KEY_DEPTH)
        else begin $error("key command sent with no credit left"); failCount++; end

    creditOwed: assert property (@(posedge clk25) disable iff (reset)
        keyCredit |-> inFlight > 0)
        else begin $error("credit returned for a command never sent"); failCount++; end

    frameSpacing: assert property (@(posedge clk25) disable iff (reset)
        frameEnd |-> frameGap == hTotal * vTotal - 1)
        else begin $error("frameEnd spacing is not one full frame"); failCount++; end

    // vsync moves only at a line start, well clear of the hsync pulse
    syncAligned: assert property (@(posedge clk25) disable iff (reset)
        (vsync != $past(vsync)) |-> hsync)
        else begin $error("vsync changed inside the hsync pulse"); failCount++; end

    deadFrozen: assert property (@(posedge clk25) disable iff (reset)
        status.dead |=> $stable(status))
        else begin $error("game status moved after the snake died"); failCount++; end

endmodule

bind snakeTop snake_sva #(.hTotal(hTotal), .vTotal(vTotal)) protocolCheck (
    .clk25, .reset, .keyCmd, .keyCredit, .frameEnd, .hsync, .vsync, .status
);

// File: tb/snakeTb.sv
`timescale 1ns/1ps
`include "snake_params.svh"

module snakeTb
    import snakeGeomPkg::*;
    import snakeCtrlPkg::*;
();
    // tiny raster, 8 by 6 tiles
    localparam int hActive = 80;
    localparam int hTotal = 100;
    localparam int hSyncStart = 84;
    localparam int hSyncEnd = 92;
    localparam int vActive = 60;
    localparam int vTotal = 70;
    localparam int vSyncStart = 62;
    localparam int vSyncEnd = 64;
    localparam int gridW = hActive / `SNAKE_TILE;
    localparam int gridH = vActive / `SNAKE_TILE;
    localparam int frameCycles = hTotal * vTotal;
    localparam int stepFrames = `SNAKE_STEP_FRAMES;

    logic clk25, reset, keyCredit, hsync, vsync;
    keyCmdT keyCmd;
    rgbT rgb;
    gameStatusT status, prevStatus;

    int patCode[$], patSteps[$], patX[$], patY[$], patLen[$], patDead[$]; // code -1 is none
    int frames = 0, sent = 0, returned = 0, stepsDone = 0;
    int pixX, pixY, prevX, prevY, expLen;
    logic prevValid;
    logic loaded = 1'b0;
    logic [31:0] rnd = 32'ha2158930;
    tileT expApple;
    tileT expBody [`SNAKE_MAX_LEN]; // slot 0 is the head

    snakeTop #(
        .hActive(hActive), .hTotal(hTotal), .hSyncStart(hSyncStart), .hSyncEnd(hSyncEnd),
        .vActive(vActive), .vTotal(vTotal), .vSyncStart(vSyncStart), .vSyncEnd(vSyncEnd)
    ) i_dut (.clk25, .reset, .keyCmd, .keyCredit, .rgb, .hsync, .vsync, .status);

    task automatic failRun();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkField(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            failRun();
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic rgbT expectColour(input int x, input int y, input gameStatusT st);
        tileT t;
        logic onBody;
        t.x = 7'(x / `SNAKE_TILE);
        t.y = 7'(y / `SNAKE_TILE);
        onBody = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            if (i < st.len && st.body[i] == t) onBody = 1'b1;
        end
        if (x >= hActive || y >= vActive || onBody) return 12'h000;
        if (t == st.apple) return 12'h0F0; // green apple
        return 12'hFFF;
    endfunction

    task automatic loadPatterns();
        int fd, n, code, steps, hx, hy, ln, dd;
        string line;
        fd = $fopen("tb/snake_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file tb/snake_patterns.txt");
            failRun();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue;
            code = -1;
            n = $sscanf(line, "none %d %d %d %d %d", steps, hx, hy, ln, dd);
            if (n != 5) n = $sscanf(line, "%h %d %d %d %d %d", code, steps, hx, hy, ln, dd) - 1;
            if (n != 5) begin
                $display("pattern line could not be read: %s", line);
                failRun();
            end
            patCode.push_back(code);
            patSteps.push_back(steps);
            patX.push_back(hx);
            patY.push_back(hy);
            patLen.push_back(ln);
            patDead.push_back(dd);
        end
        $fclose(fd);
    endtask

    // waits for a free credit, then holds the command for one cycle
    task automatic sendKey(input int code);
        while (sent - returned >= `SNAKE_KEY_DEPTH) begin
            @(posedge clk25);
            #10;
        end
        keyCmd = '{valid: 1'b1, code: 8'(code)};
        sent++;
        @(posedge clk25);
        #10;
        keyCmd = '0;
    endtask

    task automatic waitSteps(input int n);
        stepsDone += n;
        wait (frames >= stepsDone * stepFrames + 1); // one vsync past the step
        @(posedge clk25);
        #10;
    endtask

    task automatic checkStatus(input int hx, hy, ln, dd);
        checkField("status.head.x", status.head.x, hx);
        checkField("status.head.y", status.head.y, hy);
        checkField("status.len", status.len, ln);
        checkField("status.dead", status.dead, dd);
        checkField("status.apple.x", status.apple.x, expApple.x);
        checkField("status.apple.y", status.apple.y, expApple.y);
    endtask

    // a line turns at most once, on its first step, so its moves share one direction
    task automatic trackBody(input int hx, input int hy);
        int dx, dy, stepX, stepY, moves;
        tileT nextHead;
        dx = hx - int'(expBody[0].x);
        dy = hy - int'(expBody[0].y);
        stepX = (dx > 0) ? 1 : (dx < 0) ? -1 : 0;
        stepY = (dy > 0) ? 1 : (dy < 0) ? -1 : 0;
        moves = dx * stepX + dy * stepY;
        for (int k = 0; k < moves; k++) begin
            nextHead.x = 7'(int'(expBody[0].x) + stepX);
            nextHead.y = 7'(int'(expBody[0].y) + stepY);
            for (int s = `SNAKE_MAX_LEN - 1; s > 0; s--) expBody[s] = expBody[s - 1];
            expBody[0] = nextHead;
        end
    endtask

    task automatic checkBody(input int ln);
        for (int s = 1; s < ln && s < `SNAKE_MAX_LEN; s++) begin
            checkField($sformatf("status.body[%0d].x", s), status.body[s].x, expBody[s].x);
            checkField($sformatf("status.body[%0d].y", s), status.body[s].y, expBody[s].y);
        end
    endtask

    initial begin
        clk25 = 1'b0;
        forever #50 clk25 = ~clk25;
    end

    always @(negedge vsync) frames++;

    // mirror of the raster position, rgb lags it by one cycle
    always @(negedge clk25) begin
        if (reset) begin
            pixX = 0;
            pixY = 0;
            prevValid = 1'b0;
        end else begin
            if (prevValid) begin
                checkField("hsync", hsync, !(prevX >= hSyncStart && prevX < hSyncEnd));
                checkField("vsync", vsync, !(prevY >= vSyncStart && prevY < vSyncEnd));
                rnd = xorshift(rnd);
                if (rnd[2:0] == 3'd0) begin
                    checkField("rgb", rgb, expectColour(prevX, prevY, prevStatus));
                end
            end
            if (keyCredit) returned++;
            prevX = pixX;
            prevY = pixY;
            prevStatus = status;
            prevValid = 1'b1;
            pixX = (pixX == hTotal - 1) ? 0 : pixX + 1;
            if (pixX == 0) pixY = (pixY == vTotal - 1) ? 0 : pixY + 1;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = 20 * frameCycles; // reset and the final drain
        foreach (patSteps[i]) limit += longint'(patSteps[i] + 1) * stepFrames * frameCycles;
        #(limit * 100);
        $display("watchdog expired after %0d cycles with the pattern run unfinished", limit);
        failRun();
    end

    initial begin
        reset = 1'b1;
        keyCmd = '0;
        expApple = '{x: 7'd6, y: 7'd2};
        expLen = `SNAKE_START_LEN;
        foreach (expBody[s]) expBody[s] = '{x: 7'd0, y: 7'd0};
        // head at (3,0), the rest trailing to the left
        for (int s = 0; s < `SNAKE_START_LEN; s++) expBody[s].x = 7'(3 - s);
        loadPatterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk25);
        #10;
        reset = 1'b0;
        @(posedge clk25);
        #10;
        checkStatus(3, 0, 4, 0);
        checkBody(`SNAKE_START_LEN);
        foreach (patSteps[i]) begin
            if (patCode[i] >= 0) sendKey(patCode[i]);
            waitSteps(patSteps[i]);
            if (patLen[i] > expLen) begin
                // growth lines wait one step, so the apple moved one vsync ago
                expApple.x = 7'((frames - 1) % gridW);
                expApple.y = 7'((frames - 1) % gridH);
                expLen = patLen[i];
            end
            trackBody(patX[i], patY[i]);
            checkStatus(patX[i], patY[i], patLen[i], patDead[i]);
            checkBody(patLen[i]);
        end
        wait (returned >= sent);
        @(posedge clk25);
        #10;
        checkField("keyCredit pulses", returned, sent);
        if (i_dut.protocolCheck.failCount != 0) begin
            $display("bound assertions failed %0d times", i_dut.protocolCheck.failCount);
            failRun();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: tb/snake_patterns.txt
# code steps headX headY len dead
# code is a hex make code or none, expected values hold after the steps
none 1 4 0 4 0
6B 1 5 0 4 0
72 1 5 1 4 0
74 1 6 1 4 0
72 1 6 2 5 0
74 1 7 2 5 0
none 1 7 2 5 1
75 2 7 2 5 1

// File: build.f
+incdir+design
design/snakeGeomPkg.sv
design/snakeCtrlPkg.sv
design/rasterScan.sv
design/keyCommandQueue.sv
design/snakeEngine.sv
design/pixelComposer.sv
design/snakeTop.sv
tb/snake_sva.sv
tb/snakeTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = snakeTb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
